// File: ddr_cmd_arbiter.sv
/*
 * Command arbiter
 * Fixed priority init > refresh > host with a grant held until the
 * issue stage acks; the granted command is registered to the output
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_cmd_arbiter (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       init_done,
	input  wire                       init_req,
	output logic                      init_ack,
	input  wire ddr_pkg::ddr_cmd_t    init_cmd,
	input  wire [`DDR_BA_W-1:0]       init_ba,
	input  wire [`DDR_A_W-1:0]        init_a,
	input  wire                       ref_req,
	output logic                      ref_ack,
	input  wire                       host_req,
	output logic                      host_ack,
	input  wire ddr_pkg::ddr_cmd_t    host_cmd,
	input  wire [`DDR_BA_W-1:0]       host_ba,
	input  wire [`DDR_A_W-1:0]        host_a,
	output logic                      issue_req,
	input  wire                       issue_ack,
	output ddr_pkg::ddr_cmd_t         issue_cmd,
	output logic [`DDR_BA_W-1:0]      issue_ba,
	output logic [`DDR_A_W-1:0]       issue_a
);

	import ddr_pkg::*;

	logic [2:0] grant; // {host, ref, init}, one-hot or zero
	logic       sel_init, sel_ref, sel_host;

	// Init stays on top so the final MRS wins as init_done rises
	assign sel_init = init_req;
	assign sel_ref  = !sel_init && init_done && ref_req;
	assign sel_host = !sel_init && !ref_req && init_done && host_req;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			grant     <= '0;
			issue_req <= 1'b0;
		end else if (grant == '0) begin
			grant     <= {sel_host, sel_ref, sel_init};
			issue_req <= sel_init || sel_ref || sel_host;
		end else if (issue_ack) begin
			grant     <= '0;  // Release, reselect next cycle
			issue_req <= 1'b0;
		end
	end

	// Command payload, loaded on selection only
	always_ff @(posedge clk) begin
		if (grant == '0) begin
			if (sel_init) begin
				issue_cmd <= init_cmd;
				issue_ba  <= init_ba;
				issue_a   <= init_a;
			end else if (sel_ref) begin
				issue_cmd <= cmd_ar;
				issue_ba  <= '0;
				issue_a   <= '0;
			end else if (sel_host) begin
				issue_cmd <= host_cmd;
				issue_ba  <= host_ba;
				issue_a   <= host_a;
			end
		end
	end

	assign init_ack = issue_ack && grant[0];
	assign ref_ack  = issue_ack && grant[1];
	assign host_ack = issue_ack && grant[2];

	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		$onehot0({init_ack, ref_ack, host_ack}))
		else $error("more than one requester acked");

endmodule

`default_nettype wire

// File: ddr_cmd_issue.sv
/*
 * Command issue stage
 * Puts an accepted command on the DDR pins for one cycle, then
 * holds NOP for the command's recovery time
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_cmd_issue (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       issue_req,
	output logic                      issue_ack,
	input  wire ddr_pkg::ddr_cmd_t    issue_cmd,
	input  wire [`DDR_BA_W-1:0]       issue_ba,
	input  wire [`DDR_A_W-1:0]        issue_a,
	output logic                      ddr_cs_n,
	output logic                      ddr_ras_n,
	output logic                      ddr_cas_n,
	output logic                      ddr_we_n,
	output logic [`DDR_BA_W-1:0]      ddr_ba,
	output logic [`DDR_A_W-1:0]       ddr_a
);

	import ddr_pkg::*;

	localparam int gap_w = 4;

	logic [gap_w-1:0] gap_cnt;
	ddr_cmd_t         pin_cmd;

	function automatic logic [gap_w-1:0] gap_of(input ddr_cmd_t cmd);
		case (cmd)
			cmd_pre: gap_of = gap_w'(`DDR_GAP_PRE);
			cmd_ar:  gap_of = gap_w'(`DDR_GAP_AR);
			cmd_mrs: gap_of = gap_w'(`DDR_GAP_MRS);
			default: gap_of = gap_w'(`DDR_GAP_OTHER);
		endcase
	endfunction

	assign issue_ack = issue_req && (gap_cnt == '0); // Ready once the gap is over

	//------------------------------------------------------------
	// Pin registers and recovery counter
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			gap_cnt  <= '0;
			ddr_cs_n <= 1'b1;
			pin_cmd  <= cmd_nop;
			ddr_ba   <= '0;
			ddr_a    <= '0;
		end else if (issue_ack) begin
			gap_cnt  <= gap_of(issue_cmd);
			ddr_cs_n <= 1'b0;
			pin_cmd  <= issue_cmd;
			ddr_ba   <= issue_ba;
			ddr_a    <= issue_a;
		end else begin
			if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			ddr_cs_n <= 1'b1;   // Deselect between commands
			pin_cmd  <= cmd_nop;
			ddr_ba   <= '0;
			ddr_a    <= '0;
		end
	end

	assign {ddr_ras_n, ddr_cas_n, ddr_we_n} = pin_cmd;

	// A command holds the pins for one cycle only
	a_one_cycle: assert property (@(posedge clk) disable iff (reset)
		!ddr_cs_n |=> ddr_cs_n)
		else $error("command held on the pins for more than one cycle");

endmodule

`default_nettype wire

// File: ddr_ctrl_top.sv
/*
 * DDR controller command path
 * Tick, init, refresh, arbiter and issue stages wired together
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_ctrl_top (
	input  wire                       clk,
	input  wire                       reset,
	output wire                       init_done,
	input  wire                       host_req,
	output wire                       host_ack,
	input  wire ddr_pkg::ddr_cmd_t    host_cmd,
	input  wire [`DDR_BA_W-1:0]       host_ba,
	input  wire [`DDR_A_W-1:0]        host_a,
	output wire                       ddr_cs_n,
	output wire                       ddr_ras_n,
	output wire                       ddr_cas_n,
	output wire                       ddr_we_n,
	output wire [`DDR_BA_W-1:0]       ddr_ba,
	output wire [`DDR_A_W-1:0]        ddr_a
);

	import ddr_pkg::*;

	logic                 pulse78;
	logic                 init_req, init_ack;
	ddr_cmd_t             init_cmd;
	logic [`DDR_BA_W-1:0] init_ba;
	logic [`DDR_A_W-1:0]  init_a;
	logic                 ref_req, ref_ack;
	logic                 issue_req, issue_ack;
	ddr_cmd_t             issue_cmd;
	logic [`DDR_BA_W-1:0] issue_ba;
	logic [`DDR_A_W-1:0]  issue_a;

	ddr_tick_gen tick0 (.clk(clk), .reset(reset), .pulse78(pulse78));

	// wait200 is internal to the sequencer here
	ddr_init init0 (
		.clk(clk), .reset(reset), .pulse78(pulse78),
		.wait200(), .init_done(init_done),
		.init_req(init_req), .init_ack(init_ack),
		.init_cmd(init_cmd), .init_ba(init_ba), .init_a(init_a)
	);

	ddr_refresh refresh0 (
		.clk(clk), .reset(reset), .pulse78(pulse78), .init_done(init_done),
		.ref_req(ref_req), .ref_ack(ref_ack)
	);

	ddr_cmd_arbiter arb0 (
		.clk(clk), .reset(reset), .init_done(init_done),
		.init_req(init_req), .init_ack(init_ack),
		.init_cmd(init_cmd), .init_ba(init_ba), .init_a(init_a),
		.ref_req(ref_req), .ref_ack(ref_ack),
		.host_req(host_req), .host_ack(host_ack),
		.host_cmd(host_cmd), .host_ba(host_ba), .host_a(host_a),
		.issue_req(issue_req), .issue_ack(issue_ack),
		.issue_cmd(issue_cmd), .issue_ba(issue_ba), .issue_a(issue_a)
	);

	ddr_cmd_issue issue0 (
		.clk(clk), .reset(reset),
		.issue_req(issue_req), .issue_ack(issue_ack),
		.issue_cmd(issue_cmd), .issue_ba(issue_ba), .issue_a(issue_a),
		.ddr_cs_n(ddr_cs_n), .ddr_ras_n(ddr_ras_n),
		.ddr_cas_n(ddr_cas_n), .ddr_we_n(ddr_we_n),
		.ddr_ba(ddr_ba), .ddr_a(ddr_a)
	);

endmodule

`default_nettype wire

// File: ddr_init.sv
/*
 * DDR power-up sequencer
 * Waits the 200 us stable-clock time, then issues PRE ALL, EMRS,
 * MRS with DLL reset, PRE ALL, two AR and the final MRS
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_init (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  pulse78,
	output logic                 wait200,
	output logic                 init_done,
	output logic                 init_req,
	input  wire                  init_ack,
	output ddr_pkg::ddr_cmd_t    init_cmd,
	output logic [`DDR_BA_W-1:0] init_ba,
	output logic [`DDR_A_W-1:0]  init_a
);

	import ddr_pkg::*;

	localparam int wait_w = $clog2(`DDR_WAIT200_INIT + 1);
	localparam logic [`DDR_A_W-1:0] a_pre_all = `DDR_A_W'(1 << 10); // A10 selects all banks

	logic [wait_w-1:0] wait_cnt;
	init_state_t       state;

	//------------------------------------------------------------
	// 200 us wait, counted in refresh ticks
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wait_cnt <= wait_w'(`DDR_WAIT200_INIT);
			wait200  <= 1'b1;
		end else if (wait200 && pulse78) begin
			wait_cnt <= wait_cnt - 1'b1;
			if (wait_cnt == wait_w'(1))
				wait200 <= 1'b0; // Last tick seen
		end
	end

	//------------------------------------------------------------
	// Command sequence, one step per ack
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= s_wait200;
			init_done <= 1'b0;
			init_req  <= 1'b0;
			init_cmd  <= cmd_nop;
			init_ba   <= '0;
			init_a    <= '0;
		end else begin
			case (state)
				s_wait200: begin
					if (!wait200) begin
						state    <= s_init1;
						init_req <= 1'b1;
						init_cmd <= cmd_pre;    // PRE ALL
						init_a   <= a_pre_all;
					end
				end
				s_init1: begin
					if (init_ack) begin
						state    <= s_init2;
						init_cmd <= cmd_mrs;    // EMRS
						init_ba  <= 2'b01;
						init_a   <= `DDR_INIT_EMRS;
					end
				end
				s_init2: begin
					if (init_ack) begin
						state    <= s_init3;
						init_cmd <= cmd_mrs;    // MRS, DLL reset
						init_ba  <= 2'b00;
						init_a   <= `DDR_INIT_MRS1;
					end
				end
				s_init3: begin
					if (init_ack) begin
						state    <= s_init4;
						init_cmd <= cmd_pre;
						init_a   <= a_pre_all;
					end
				end
				s_init4: begin
					if (init_ack) begin
						state    <= s_init5;
						init_cmd <= cmd_ar;
						init_a   <= '0;
					end
				end
				s_init5: begin
					if (init_ack)
						state <= s_init6; // Second AR, same fields
				end
				s_init6: begin
					if (init_ack) begin
						state     <= s_waitack;
						init_done <= 1'b1;
						init_cmd  <= cmd_mrs; // Final MRS
						init_ba   <= 2'b00;
						init_a    <= `DDR_INIT_MRS2;
					end
				end
				s_waitack: begin
					if (init_ack) begin
						state    <= s_idle;
						init_req <= 1'b0;
						init_cmd <= cmd_nop;
						init_ba  <= '0;
						init_a   <= '0;
					end
				end
				default: ; // Idle for good
			endcase
		end
	end

	// Fields hold while a request waits
	a_init_stable: assert property (@(posedge clk) disable iff (reset)
		init_req && !init_ack |=> init_req && $stable({init_cmd, init_ba, init_a}))
		else $error("init command changed before ack");

endmodule

`default_nettype wire

// File: ddr_macros.svh
/*
 * DDR controller timing and mode register constants
 * Simulation-scaled counts for the refresh tick and power-up wait
 */
`ifndef DDR_MACROS_SVH
`define DDR_MACROS_SVH

// Address bus widths
`define DDR_A_W            13
`define DDR_BA_W           2

// Refresh tick and power-up wait
`define DDR_TICK_DIV       64     // Clocks per refresh tick
`define DDR_WAIT200_INIT   4      // Ticks before the power-up sequence

// Mode register values
`define DDR_INIT_EMRS      13'h000  // DLL enable, normal drive
`define DDR_INIT_MRS1      13'h122  // CL2, BL4 sequential, DLL reset
`define DDR_INIT_MRS2      13'h022  // CL2, BL4 sequential

// NOP cycles after each command
`define DDR_GAP_PRE        2      // tRP
`define DDR_GAP_AR         7      // tRFC
`define DDR_GAP_MRS        2      // tMRD
`define DDR_GAP_OTHER      1

// Refresh postponement limit
`define DDR_REF_PEND_MAX   8

`endif

// File: ddr_patterns.txt
// Host commands, one per line: cmd {ras_n,cas_n,we_n}, bank, address (hex)
// Commands used: 3 ACT, 5 RD, 4 WR, 2 PRE, 0 MRS
3 1 0a5c  // ACT
5 1 0010  // RD
4 1 0018  // WR
2 1 0000  // PRE
3 2 1fff  // ACT
4 2 0400  // WR with auto precharge
5 2 0200  // RD
3 0 0001  // ACT
5 0 0600  // RD with auto precharge
2 0 0400  // PRE all
0 3 0000  // MRS
3 3 1234  // ACT
4 3 0ff8  // WR
5 3 0008  // RD

// File: ddr_pkg.sv
/*
 * DDR controller shared types
 * Command encoding on {ras_n, cas_n, we_n} and init FSM states
 */
`default_nettype none

package ddr_pkg;

	typedef enum logic [2:0] {
		cmd_mrs = 3'b000,
		cmd_ar  = 3'b001,
		cmd_pre = 3'b010,
		cmd_act = 3'b011,
		cmd_wr  = 3'b100,
		cmd_rd  = 3'b101,
		cmd_nop = 3'b111
	} ddr_cmd_t;

	// Power-up sequencer states
	typedef enum logic [3:0] {
		s_wait200, s_init1, s_init2, s_init3, s_init4,
		s_init5, s_init6, s_waitack, s_idle
	} init_state_t;

endpackage

`default_nettype wire

// File: ddr_refresh.sv
/*
 * Refresh scheduler
 * Queues one auto-refresh per tick after init, up to the
 * postponement limit, and requests them until acked
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_refresh (
	input  wire  clk,
	input  wire  reset,
	input  wire  pulse78,
	input  wire  init_done,
	output logic ref_req,
	input  wire  ref_ack
);

	localparam int pend_w = $clog2(`DDR_REF_PEND_MAX + 1);
	localparam logic [pend_w-1:0] pend_max = pend_w'(`DDR_REF_PEND_MAX);

	logic [pend_w-1:0] pend_cnt;
	logic              add_ref;

	assign add_ref = pulse78 && init_done && (pend_cnt != pend_max);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pend_cnt <= '0;
		end else begin
			case ({add_ref, ref_ack})
				2'b10:   pend_cnt <= pend_cnt + 1'b1;
				2'b01:   pend_cnt <= pend_cnt - 1'b1;
				default: ; // None or both
			endcase
		end
	end

	assign ref_req = (pend_cnt != '0);

	// Pending count stays within the postponement limit
	a_pend_sat: assert property (@(posedge clk) disable iff (reset)
		pend_cnt <= pend_max)
		else $error("refresh pending count passed its limit");

endmodule

`default_nettype wire

// File: ddr_tick_gen.sv
/*
 * Refresh tick generator
 * Free-running divider, one-cycle pulse per refresh interval
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module ddr_tick_gen (
	input  wire  clk,
	input  wire  reset,
	output logic pulse78
);

	localparam int cnt_w = $clog2(`DDR_TICK_DIV);

	logic [cnt_w-1:0] tick_cnt;

	// Count down, pulse and reload on wrap
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tick_cnt <= cnt_w'(`DDR_TICK_DIV - 1);
			pulse78  <= 1'b0;
		end else if (tick_cnt == '0) begin
			tick_cnt <= cnt_w'(`DDR_TICK_DIV - 1);
			pulse78  <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt - 1'b1;
			pulse78  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the DDR command path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_ddr_ctrl -o tb_ddr_ctrl
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/tb_ddr_ctrl 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
	exit 0
else
	echo "Pass line not found in simulation output"
	exit 1
fi

// File: sim.f
+incdir+.
ddr_pkg.sv
ddr_tick_gen.sv
ddr_init.sv
ddr_refresh.sv
ddr_cmd_arbiter.sv
ddr_cmd_issue.sv
ddr_ctrl_top.sv
tb_ddr_checker.sv
tb_ddr_ctrl.sv

// File: tb_ddr_checker.sv
/*
 * DDR pin monitor for the command path testbench
 * Decodes the command pins and checks reset state, power-up order,
 * host command order, recovery gaps and refresh rate
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module tb_ddr_checker #(
	parameter int n_pat = 14
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 init_done,
	input  wire                 ddr_cs_n,
	input  wire                 ddr_ras_n,
	input  wire                 ddr_cas_n,
	input  wire                 ddr_we_n,
	input  wire [`DDR_BA_W-1:0] ddr_ba,
	input  wire [`DDR_A_W-1:0]  ddr_a,
	input  wire [15:0]          pat_mem [0:3*n_pat-1],
	input  wire                 run_end,
	output wire [31:0]          err_cnt,
	output wire                 chk_done
);

	import ddr_pkg::*;

	localparam int wait_cycles = `DDR_WAIT200_INIT * `DDR_TICK_DIV;

	int   errs = 0;
	int   cyc = 0;
	int   done_cyc = 0;       // Cycles with init_done high
	int   init_idx = 0;
	int   pat_idx = 0;
	int   ar_seen = 0;        // Refreshes after power-up
	int   nop_run = 0;
	int   need_gap = 0;
	bit   have_prev = 1'b0;
	bit   was_reset = 1'b0;
	logic checks_done = 1'b0;

	assign err_cnt  = errs;
	assign chk_done = checks_done;

	// Recovery NOPs owed after a command
	function automatic int gap_after(input logic [2:0] c);
		case (c)
			cmd_pre: gap_after = `DDR_GAP_PRE;
			cmd_ar:  gap_after = `DDR_GAP_AR;
			cmd_mrs: gap_after = `DDR_GAP_MRS;
			default: gap_after = `DDR_GAP_OTHER;
		endcase
	endfunction

	task automatic check_field(input string name, input logic [15:0] got,
			input logic [15:0] exp, input string ctx);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h (%s)", name, got, exp, ctx);
			errs++;
		end
	endtask

	//------------------------------------------------------------
	// Power-up sequence, one step per command seen
	//------------------------------------------------------------
	task automatic check_init(input int idx, input logic [2:0] c);
		string ctx;
		ctx = $sformatf("init step %0d", idx);
		case (idx)
			0, 3: begin
				check_field("ddr_cmd", 16'(c), 16'(cmd_pre), ctx);
				check_field("ddr_a[10]", 16'(ddr_a[10]), 16'h1, ctx); // Precharge all
			end
			4, 5: check_field("ddr_cmd", 16'(c), 16'(cmd_ar), ctx);
			default: begin
				check_field("ddr_cmd", 16'(c), 16'(cmd_mrs), ctx);
				check_field("ddr_ba", 16'(ddr_ba), (idx == 1) ? 16'h1 : 16'h0, ctx);
				check_field("ddr_a", 16'(ddr_a), (idx == 1) ? 16'(`DDR_INIT_EMRS) :
					(idx == 2) ? 16'(`DDR_INIT_MRS1) : 16'(`DDR_INIT_MRS2), ctx);
			end
		endcase
		if (idx == 6)
			check_field("init_done", 16'(init_done), 16'h1, ctx);
		if (cyc < wait_cycles) begin
			$display("init command at cycle %0d, inside the %0d-cycle power-up wait",
				cyc, wait_cycles);
			errs++;
		end
	endtask

	task automatic check_pattern(input int idx, input logic [2:0] c);
		string ctx;
		ctx = $sformatf("pattern entry %0d", idx);
		check_field("ddr_cmd", 16'(c), 16'(pat_mem[3*idx][2:0]), ctx);
		check_field("ddr_ba", 16'(ddr_ba), 16'(pat_mem[3*idx+1][`DDR_BA_W-1:0]), ctx);
		check_field("ddr_a", 16'(ddr_a), 16'(pat_mem[3*idx+2][`DDR_A_W-1:0]), ctx);
	endtask

	//------------------------------------------------------------
	// Pin sampling, mid-cycle
	//------------------------------------------------------------
	always @(negedge clk) begin
		logic [2:0] cmd_now;
		int         exp_ar;
		cmd_now = {ddr_ras_n, ddr_cas_n, ddr_we_n};
		if (reset || was_reset) begin
			check_field("ddr_cs_n", 16'(ddr_cs_n), 16'h1, "reset");
			check_field("ddr_cmd", 16'(cmd_now), 16'(cmd_nop), "reset");
			check_field("ddr_ba", 16'(ddr_ba), 16'h0, "reset");
			check_field("ddr_a", 16'(ddr_a), 16'h0, "reset");
			check_field("init_done", 16'(init_done), 16'h0, "reset");
		end
		was_reset = reset;
		if (!reset) begin
			cyc++;
			if (init_done)
				done_cyc++;
			if (!ddr_cs_n && cmd_now != cmd_nop) begin
				if (have_prev && nop_run < need_gap) begin
					$display("command %h came after %0d NOP cycles, %0d required",
						cmd_now, nop_run, need_gap);
					errs++;
				end
				have_prev = 1'b1;
				need_gap  = gap_after(cmd_now);
				nop_run   = 0;
				if (init_idx < 7) begin
					check_init(init_idx, cmd_now); // Host commands land here too early
					init_idx++;
				end else if (cmd_now == cmd_ar) begin
					ar_seen++;
				end else if (pat_idx < n_pat) begin
					check_pattern(pat_idx, cmd_now);
					pat_idx++;
				end else begin
					$display("unexpected command %h after the last pattern entry", cmd_now);
					errs++;
				end
			end else begin
				nop_run++;
			end
		end
		if (run_end && !checks_done) begin
			if (init_idx != 7) begin
				$display("power-up sequence incomplete, %0d of 7 commands seen", init_idx);
				errs++;
			end
			if (pat_idx != n_pat) begin
				$display("only %0d of %0d pattern entries were seen", pat_idx, n_pat);
				errs++;
			end
			exp_ar = done_cyc / `DDR_TICK_DIV;
			if (ar_seen > exp_ar + 1 || ar_seen + 1 < exp_ar) begin
				$display("refresh count %0d is not within one of %0d", ar_seen, exp_ar);
				errs++;
			end
			checks_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: tb_ddr_ctrl.sv
/*
 * Testbench for the DDR command path
 * Replays host commands from the pattern file with random idle gaps
 */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_macros.svh"

module tb_ddr_ctrl;

	import ddr_pkg::*;

	localparam int n_pat       = 14;
	localparam int ack_timeout = 2000;  // Covers the power-up wait
	localparam int end_timeout = 8;

	logic                 clk;
	logic                 reset;
	logic                 host_req;
	ddr_cmd_t             host_cmd;
	logic [`DDR_BA_W-1:0] host_ba;
	logic [`DDR_A_W-1:0]  host_a;
	logic                 run_end;
	wire                  host_ack;
	wire                  init_done;
	wire                  ddr_cs_n, ddr_ras_n, ddr_cas_n, ddr_we_n;
	wire [`DDR_BA_W-1:0]  ddr_ba;
	wire [`DDR_A_W-1:0]   ddr_a;
	wire [31:0]           chk_errors;
	wire                  chk_done;

	logic [15:0] pat_mem [0:3*n_pat-1]; // cmd, bank, address per entry
	logic [7:0]  lfsr;
	int          timeouts;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	ddr_ctrl_top dut0 (
		.clk(clk), .reset(reset), .init_done(init_done),
		.host_req(host_req), .host_ack(host_ack),
		.host_cmd(host_cmd), .host_ba(host_ba), .host_a(host_a),
		.ddr_cs_n(ddr_cs_n), .ddr_ras_n(ddr_ras_n),
		.ddr_cas_n(ddr_cas_n), .ddr_we_n(ddr_we_n),
		.ddr_ba(ddr_ba), .ddr_a(ddr_a)
	);

	tb_ddr_checker #(.n_pat(n_pat)) chk0 (
		.clk(clk), .reset(reset), .init_done(init_done),
		.ddr_cs_n(ddr_cs_n), .ddr_ras_n(ddr_ras_n),
		.ddr_cas_n(ddr_cas_n), .ddr_we_n(ddr_we_n),
		.ddr_ba(ddr_ba), .ddr_a(ddr_a), .pat_mem(pat_mem),
		.run_end(run_end), .err_cnt(chk_errors), .chk_done(chk_done)
	);

	// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] galois_step(input logic [7:0] s);
		if (s[0])
			galois_step = (s >> 1) ^ 8'hb8;
		else
			galois_step = s >> 1;
	endfunction

	//------------------------------------------------------------
	// Host side handshake
	//------------------------------------------------------------
	task automatic send_entry(input int idx, output bit acked);
		int waited;
		@(posedge clk);
		host_req <= 1'b1;
		host_cmd <= ddr_cmd_t'(pat_mem[3*idx][2:0]);
		host_ba  <= pat_mem[3*idx+1][`DDR_BA_W-1:0];
		host_a   <= pat_mem[3*idx+2][`DDR_A_W-1:0];
		acked  = 1'b0;
		waited = 0;
		while (!acked && waited < ack_timeout) begin
			@(negedge clk);
			acked = host_ack;
			waited++;
		end
		if (!acked)
			$display("host_ack did not arrive within %0d cycles for pattern entry %0d",
				ack_timeout, idx);
	endtask

	// Zero to seven idle cycles, one LFSR step per bit
	task automatic idle_gap();
		int n;
		int i;
		n = 0;
		for (i = 0; i < 3; i++) begin
			n    = n * 2 + int'(lfsr[0]);
			lfsr = galois_step(lfsr);
		end
		if (n > 0) begin
			@(posedge clk);
			host_req <= 1'b0;
			repeat (n - 1) @(posedge clk);
		end
	endtask

	initial begin
		int i;
		bit ok;
		bit seen;
		int waited;
		reset    = 1'b1;
		host_req = 1'b0;
		host_cmd = cmd_nop;
		host_ba  = '0;
		host_a   = '0;
		run_end  = 1'b0;
		timeouts = 0;
		lfsr     = 8'd89;
		$readmemh("ddr_patterns.txt", pat_mem);
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Host requests start while power-up is still running
		ok = 1'b1;
		i  = 0;
		while (ok && i < n_pat) begin
			send_entry(i, ok);
			if (ok)
				idle_gap();
			i++;
		end
		if (ok) begin
			@(posedge clk);
			host_req <= 1'b0;
			repeat (2 * `DDR_TICK_DIV) @(posedge clk); // Two refresh intervals
		end else begin
			timeouts++;
		end

		@(posedge clk);
		run_end <= 1'b1;
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < end_timeout) begin
			@(negedge clk);
			seen = chk_done;
			waited++;
		end
		if (!seen) begin
			$display("checker did not finish its final checks in time");
			timeouts++;
		end
		$display("Closing counts: %0d checker errors, %0d timeouts", chk_errors, timeouts);
		if (chk_errors == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
